// ==== vlog.f ====
dsp_pkg.sv
dsp_cfg_if.sv
dsp_cfg_regs.sv
code_history.sv
ffe_filter.sv
bit_slicer.sv
mlsd_checker.sv
dsp_backend.sv
tb_dsp_backend.sv

// ==== tb_dsp_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_backend;

	localparam int nl = dsp_pkg::default_lanes;
	localparam int taps = dsp_pkg::default_taps;
	// symbols before the first word still get a valid index.
	localparam int off = 32;
	localparam int max_sym = 8192;
	// the tests take close to 400 cycles.
	localparam int max_cycles = 1500;

	typedef logic signed [dsp_pkg::code_w-1:0] word_t [nl];

	logic clk;
	logic rstb;
	word_t codes_i;
	logic cfg_wr_i;
	dsp_pkg::cfg_sel_e cfg_sel_i;
	logic [dsp_pkg::idx_w(nl)-1:0] cfg_lane_i;
	logic [dsp_pkg::tap_idx_w(taps)-1:0] cfg_tap_i;
	logic signed [dsp_pkg::code_w-1:0] cfg_data_i;
	word_t estimated_bits_o;
	logic [nl-1:0] checked_bits_o;

	logic [31:0] seed = 32'h5ce4_4559;
	int cycles = 0;

	// register contents as the DUT holds them.
	int sh_wt [nl][taps];
	int sh_th [nl];
	int sh_fs [nl];
	int sh_ms [nl];
	int sh_ce [nl][dsp_pkg::num_cursors];

	int sym_q [$];
	int est_m [max_sym];
	bit bit_m [max_sym];
	bit tx_m [max_sym];
	int tx_lo = 1;
	int tx_hi = 0;
	bit tx_on;
	word_t exp_est = '{default: '0};
	logic [nl-1:0] exp_chk = '0;
	logic [nl-1:0] exp_tx = '0;

	dsp_backend DUT (
		.clk(clk),
		.rstb(rstb),
		.codes_i(codes_i),
		.cfg_wr_i(cfg_wr_i),
		.cfg_sel_i(cfg_sel_i),
		.cfg_lane_i(cfg_lane_i),
		.cfg_tap_i(cfg_tap_i),
		.cfg_data_i(cfg_data_i),
		.estimated_bits_o(estimated_bits_o),
		.checked_bits_o(checked_bits_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first failure");
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			stop_run($sformatf("simulation did not finish within %0d cycles", max_cycles));
		end
	end

	// checked bits seen at the falling edge, against the prediction for the last edge.
	assert property (@(negedge clk) disable iff (!rstb) checked_bits_o == exp_chk)
		else stop_run($sformatf("** Error @ %0t: checked_bits_o %b, expected %b",
			$time, $sampled(checked_bits_o), $sampled(exp_chk)));

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int sym_at(input int i);
		return (i < 0) ? 0 : sym_q[i];
	endfunction

	task automatic rand_word(output word_t w);
		logic [31:0] r;
		for (int l = 0; l < nl; l++) begin
			r = lcg_next();
			w[l] = r[30:23];
		end
	endtask

	task automatic check_outputs();
		for (int l = 0; l < nl; l++) begin
			assert (estimated_bits_o[l] == exp_est[l])
				else stop_run($sformatf("** Error @ %0t: lane %0d estimate %0d, expected %0d",
					$time, l, estimated_bits_o[l], exp_est[l]));
		end
		if (tx_on) begin
			assert (checked_bits_o == exp_tx)
				else stop_run($sformatf("** Error @ %0t: checked bits %b, sent bits %b",
					$time, checked_bits_o, exp_tx));
		end
	endtask

	// outputs of the coming rising edge, from the symbol stream and the registers.
	task automatic predict(input word_t w);
		int t;
		int i;
		int acc;
		int isi;
		int p0;
		int p1;
		int e0;
		int e1;
		t = sym_q.size() / nl;
		for (int l = 0; l < nl; l++) begin
			sym_q.push_back(w[l]);
		end
		for (int l = 0; l < nl; l++) begin
			acc = 0;
			for (int k = 0; k < taps; k++) begin
				acc = acc + sh_wt[l][k] * sym_at((t - 1) * nl + l - k);
			end
			acc = acc >>> sh_fs[l];
			if (acc > 127) begin
				acc = 127;
			end else if (acc < -128) begin
				acc = -128;
			end
			est_m[(t - 1) * nl + l + off] = acc;
			exp_est[l] = acc;
			i = (t - 2) * nl + l + off;
			bit_m[i] = (est_m[i] >= sh_th[l]);
		end
		for (int l = 0; l < nl; l++) begin
			i = (t - 4) * nl + l;
			isi = bit_m[i + 1 + off] ? sh_ce[l][0] : -sh_ce[l][0];
			isi = isi + (bit_m[i - 1 + off] ? sh_ce[l][2] : -sh_ce[l][2]);
			p1 = (isi + sh_ce[l][1]) >>> sh_ms[l];
			p0 = (isi - sh_ce[l][1]) >>> sh_ms[l];
			e1 = (sym_at(i) > p1) ? sym_at(i) - p1 : p1 - sym_at(i);
			e0 = (sym_at(i) > p0) ? sym_at(i) - p0 : p0 - sym_at(i);
			exp_chk[l] = (e1 < e0) ? 1'b1 : (e0 < e1) ? 1'b0 : bit_m[i + off];
			exp_tx[l] = tx_m[i + off];
		end
		tx_on = (t - 4 >= tx_lo) && (t - 4 <= tx_hi);
	endtask

	// one cycle, starting and ending on a falling edge.
	task automatic advance(input word_t w);
		check_outputs();
		predict(w);
		codes_i = w;
		@(negedge clk);
	endtask

	task automatic run_random(input int words);
		word_t w;
		for (int n = 0; n < words; n++) begin
			rand_word(w);
			advance(w);
		end
	endtask

	task automatic cfg_write(input dsp_pkg::cfg_sel_e sel, input int lane, input int tap,
		input int data);
		logic signed [dsp_pkg::code_w-1:0] d;
		word_t w;
		d = data[7:0];
		rand_word(w);
		cfg_wr_i = 1'b1;
		cfg_sel_i = sel;
		cfg_lane_i = lane[1:0];
		cfg_tap_i = tap[1:0];
		cfg_data_i = d;
		advance(w);
		cfg_wr_i = 1'b0;
		// the register took the value at the last rising edge.
		case (sel)
			dsp_pkg::sel_weight: sh_wt[lane][tap] = d;
			dsp_pkg::sel_thresh: sh_th[lane] = d;
			dsp_pkg::sel_ffe_shift: sh_fs[lane] = d[3:0];
			dsp_pkg::sel_mlsd_shift: sh_ms[lane] = d[3:0];
			default: sh_ce[lane][tap] = d;
		endcase
	endtask

	task automatic set_identity();
		for (int l = 0; l < nl; l++) begin
			cfg_write(dsp_pkg::sel_weight, l, 0, 16);
			cfg_write(dsp_pkg::sel_weight, l, 1, 0);
			cfg_write(dsp_pkg::sel_weight, l, 2, 0);
			cfg_write(dsp_pkg::sel_ffe_shift, l, 0, 4);
		end
	endtask

	task automatic slicer_test();
		int th [nl];
		int deltas [5];
		word_t w;
		th = '{10, -20, 0, 55};
		deltas = '{-1, 0, 1, -50, 40};
		set_identity();
		for (int l = 0; l < nl; l++) begin
			cfg_write(dsp_pkg::sel_thresh, l, 0, th[l]);
		end
		for (int d = 0; d < 5; d++) begin
			for (int l = 0; l < nl; l++) begin
				w[l] = th[l] + deltas[d];
			end
			advance(w);
		end
		run_random(20);
	endtask

	task automatic mlsd_test(input int words);
		bit tx_bits [$];
		int base;
		int m;
		int code;
		logic [31:0] r;
		word_t w;
		for (int l = 0; l < nl; l++) begin
			cfg_write(dsp_pkg::sel_thresh, l, 0, 0);
			cfg_write(dsp_pkg::sel_chan_est, l, 0, 8);
			cfg_write(dsp_pkg::sel_chan_est, l, 1, 32);
			cfg_write(dsp_pkg::sel_chan_est, l, 2, 8);
			cfg_write(dsp_pkg::sel_mlsd_shift, l, 0, 0);
		end
		base = sym_q.size();
		// one extra bit on each side of the block.
		for (int j = 0; j < words * nl + 2; j++) begin
			r = lcg_next();
			tx_bits.push_back(r[31]);
		end
		// edge words see random neighbours.
		tx_lo = base / nl + 1;
		tx_hi = base / nl + words - 2;
		for (int n = 0; n < words; n++) begin
			for (int l = 0; l < nl; l++) begin
				m = n * nl + l;
				code = (tx_bits[m + 2] ? 8 : -8) + (tx_bits[m + 1] ? 32 : -32);
				code = code + (tx_bits[m] ? 8 : -8);
				// weak isolated symbol pushed over the threshold.
				if (m % 5 == 2 && (code == 16 || code == -16)) begin
					code = (code > 0) ? -2 : 2;
				end
				w[l] = code;
				tx_m[base + m + off] = tx_bits[m + 1];
			end
			advance(w);
		end
	endtask

	initial begin
		logic [31:0] r;
		rstb = 1'b0;
		codes_i = '{default: '0};
		cfg_wr_i = 1'b0;
		cfg_sel_i = dsp_pkg::sel_weight;
		cfg_lane_i = '0;
		cfg_tap_i = '0;
		cfg_data_i = '0;
		repeat (3) @(negedge clk);
		rstb = 1'b1;

		set_identity();
		run_random(20);

		// random weights and small shifts, so sums often saturate.
		for (int l = 0; l < nl; l++) begin
			for (int k = 0; k < taps; k++) begin
				r = lcg_next();
				cfg_write(dsp_pkg::sel_weight, l, k, r[31:24]);
			end
			r = lcg_next();
			cfg_write(dsp_pkg::sel_ffe_shift, l, 0, r[31:29]);
		end
		run_random(200);

		slicer_test();
		mlsd_test(40);

		// single-lane writes in the middle of the stream.
		cfg_write(dsp_pkg::sel_weight, 2, 1, 40);
		run_random(8);
		cfg_write(dsp_pkg::sel_chan_est, 1, 0, -24);
		run_random(8);
		cfg_write(dsp_pkg::sel_thresh, 3, 0, 12);
		run_random(8);
		run_random(6);

		// results of the last word.
		check_outputs();
		@(posedge clk);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dsp_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_backend #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [dsp_pkg::code_w-1:0] codes_i [num_lanes],
	input wire logic cfg_wr_i,
	input dsp_pkg::cfg_sel_e cfg_sel_i,
	input wire logic [dsp_pkg::idx_w(num_lanes)-1:0] cfg_lane_i,
	input wire logic [dsp_pkg::tap_idx_w(ffe_taps)-1:0] cfg_tap_i,
	input wire logic signed [dsp_pkg::code_w-1:0] cfg_data_i,
	output logic signed [dsp_pkg::code_w-1:0] estimated_bits_o [num_lanes],
	output logic [num_lanes-1:0] checked_bits_o
);

	localparam int hist_len = dsp_pkg::hist_words(num_lanes, ffe_taps) * num_lanes;

	logic signed [dsp_pkg::code_w-1:0] hist [hist_len];
	logic [num_lanes-1:0] bit_hist [3];

	dsp_cfg_if #(.num_lanes(num_lanes), .ffe_taps(ffe_taps)) cfg_bus ();

	dsp_cfg_regs #(.num_lanes(num_lanes), .ffe_taps(ffe_taps)) u_cfg_regs (
		.clk(clk),
		.rstb(rstb),
		.cfg_wr_i(cfg_wr_i),
		.cfg_sel_i(cfg_sel_i),
		.cfg_lane_i(cfg_lane_i),
		.cfg_tap_i(cfg_tap_i),
		.cfg_data_i(cfg_data_i),
		.cfg_o(cfg_bus.regs)
	);

	code_history #(.num_lanes(num_lanes), .ffe_taps(ffe_taps)) u_code_history (
		.clk(clk),
		.rstb(rstb),
		.codes_i(codes_i),
		.hist_o(hist)
	);

	ffe_filter #(.num_lanes(num_lanes), .ffe_taps(ffe_taps)) u_ffe (
		.clk(clk),
		.rstb(rstb),
		.hist_i(hist),
		.cfg_i(cfg_bus.user),
		.est_o(estimated_bits_o)
	);

	// the checker reads the slicer decisions from the bit history only.
	bit_slicer #(.num_lanes(num_lanes), .ffe_taps(ffe_taps)) u_slicer (
		.clk(clk),
		.rstb(rstb),
		.est_i(estimated_bits_o),
		.cfg_i(cfg_bus.user),
		.bits_o(),
		.bit_hist_o(bit_hist)
	);

	mlsd_checker #(.num_lanes(num_lanes), .ffe_taps(ffe_taps)) u_mlsd (
		.clk(clk),
		.rstb(rstb),
		.hist_i(hist),
		.bit_hist_i(bit_hist),
		.cfg_i(cfg_bus.user),
		.checked_o(checked_bits_o)
	);

endmodule

`default_nettype wire

// ==== mlsd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlsd_checker #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps,
	localparam int hist_len = dsp_pkg::hist_words(num_lanes, ffe_taps) * num_lanes
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [dsp_pkg::code_w-1:0] hist_i [hist_len],
	input wire logic [num_lanes-1:0] bit_hist_i [3],
	dsp_cfg_if.user cfg_i,
	output logic [num_lanes-1:0] checked_o
);

	localparam int pw = ((dsp_pkg::code_w > dsp_pkg::est_w) ?
		dsp_pkg::code_w : dsp_pkg::est_w) + 3;

	// oldest word in the low bits, so index order is symbol order.
	logic [3*num_lanes-1:0] seq;
	logic [num_lanes-1:0] checked_d;

	assign seq = {bit_hist_i[0], bit_hist_i[1], bit_hist_i[2]};

	for (genvar l = 0; l < num_lanes; l++) begin : g_lane
		logic signed [pw-1:0] isi;
		logic signed [pw-1:0] pred0;
		logic signed [pw-1:0] pred1;
		logic signed [pw-1:0] code;
		logic signed [pw-1:0] err0;
		logic signed [pw-1:0] err1;

		always_comb begin
			isi = '0;
			// next symbol through the pre cursor.
			if (seq[num_lanes + l + 1]) begin
				isi = isi + cfg_i.chan_est[l][0];
			end else begin
				isi = isi - cfg_i.chan_est[l][0];
			end
			// previous symbol through the post cursor.
			if (seq[num_lanes + l - 1]) begin
				isi = isi + cfg_i.chan_est[l][2];
			end else begin
				isi = isi - cfg_i.chan_est[l][2];
			end
			pred1 = (isi + cfg_i.chan_est[l][1]) >>> cfg_i.mlsd_shift[l];
			pred0 = (isi - cfg_i.chan_est[l][1]) >>> cfg_i.mlsd_shift[l];
			code = hist_i[dsp_pkg::mlsd_word * num_lanes + num_lanes - 1 - l];
			err0 = code - pred0;
			err1 = code - pred1;
			if (err0 < 0) begin
				err0 = -err0;
			end
			if (err1 < 0) begin
				err1 = -err1;
			end
			if (err1 < err0) begin
				checked_d[l] = 1'b1;
			end else if (err0 < err1) begin
				checked_d[l] = 1'b0;
			end else begin
				checked_d[l] = seq[num_lanes + l];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			checked_o <= '0;
		end else begin
			checked_o <= checked_d;
		end
	end

endmodule

`default_nettype wire

// ==== bit_slicer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_slicer #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [dsp_pkg::code_w-1:0] est_i [num_lanes],
	dsp_cfg_if.user cfg_i,
	output logic [num_lanes-1:0] bits_o,
	output logic [num_lanes-1:0] bit_hist_o [3]
);

	logic [num_lanes-1:0] bits_d;
	logic [num_lanes-1:0] bits_q1;
	logic [num_lanes-1:0] bits_q2;

	// ties decide 1.
	always_comb begin
		for (int l = 0; l < num_lanes; l++) begin
			bits_d[l] = (est_i[l] >= cfg_i.thresh[l]);
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_o <= '0;
			bits_q1 <= '0;
			bits_q2 <= '0;
		end else begin
			bits_o <= bits_d;
			bits_q1 <= bits_o;
			bits_q2 <= bits_q1;
		end
	end

	// word 0 is the newest.
	assign bit_hist_o[0] = bits_o;
	assign bit_hist_o[1] = bits_q1;
	assign bit_hist_o[2] = bits_q2;

endmodule

`default_nettype wire

// ==== ffe_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ffe_filter #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps,
	localparam int hist_len = dsp_pkg::hist_words(num_lanes, ffe_taps) * num_lanes
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [dsp_pkg::code_w-1:0] hist_i [hist_len],
	dsp_cfg_if.user cfg_i,
	output logic signed [dsp_pkg::code_w-1:0] est_o [num_lanes]
);

	localparam int acc_w = dsp_pkg::code_w + dsp_pkg::weight_w + $clog2(ffe_taps);

	localparam logic signed [dsp_pkg::code_w-1:0] est_max = {1'b0, {(dsp_pkg::code_w-1){1'b1}}};
	localparam logic signed [dsp_pkg::code_w-1:0] est_min = {1'b1, {(dsp_pkg::code_w-1){1'b0}}};

	logic signed [dsp_pkg::code_w-1:0] est_d [num_lanes];

	for (genvar l = 0; l < num_lanes; l++) begin : g_lane
		logic signed [acc_w-1:0] acc;
		logic signed [acc_w-1:0] shifted;

		always_comb begin
			acc = '0;
			// tap k looks k symbols back from this lane.
			for (int k = 0; k < ffe_taps; k++) begin
				acc = acc + cfg_i.weights[l][k] * hist_i[num_lanes - 1 - l + k];
			end
			shifted = acc >>> cfg_i.ffe_shift[l];
			if (shifted > est_max) begin
				est_d[l] = est_max;
			end else if (shifted < est_min) begin
				est_d[l] = est_min;
			end else begin
				est_d[l] = shifted[dsp_pkg::code_w-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int l = 0; l < num_lanes; l++) begin
				est_o[l] <= '0;
			end
		end else begin
			for (int l = 0; l < num_lanes; l++) begin
				est_o[l] <= est_d[l];
			end
		end
	end

endmodule

`default_nettype wire

// ==== code_history.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_history #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps,
	localparam int hist_len = dsp_pkg::hist_words(num_lanes, ffe_taps) * num_lanes
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic signed [dsp_pkg::code_w-1:0] codes_i [num_lanes],
	output logic signed [dsp_pkg::code_w-1:0] hist_o [hist_len]
);

	// age 0 is the newest symbol, i.e. the last lane of the newest word.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int a = 0; a < hist_len; a++) begin
				hist_o[a] <= '0;
			end
		end else begin
			for (int a = 0; a < num_lanes; a++) begin
				hist_o[a] <= codes_i[num_lanes - 1 - a];
			end
			// older words move one word deeper.
			for (int a = num_lanes; a < hist_len; a++) begin
				hist_o[a] <= hist_o[a - num_lanes];
			end
		end
	end

endmodule

`default_nettype wire

// ==== dsp_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_cfg_regs #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic cfg_wr_i,
	input dsp_pkg::cfg_sel_e cfg_sel_i,
	input wire logic [dsp_pkg::idx_w(num_lanes)-1:0] cfg_lane_i,
	input wire logic [dsp_pkg::tap_idx_w(ffe_taps)-1:0] cfg_tap_i,
	input wire logic signed [dsp_pkg::code_w-1:0] cfg_data_i,
	dsp_cfg_if.regs cfg_o
);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int l = 0; l < num_lanes; l++) begin
				cfg_o.thresh[l] <= '0;
				cfg_o.ffe_shift[l] <= '0;
				cfg_o.mlsd_shift[l] <= '0;
				for (int t = 0; t < ffe_taps; t++) begin
					cfg_o.weights[l][t] <= '0;
				end
				for (int c = 0; c < dsp_pkg::num_cursors; c++) begin
					cfg_o.chan_est[l][c] <= '0;
				end
			end
		end else if (cfg_wr_i) begin
			for (int l = 0; l < num_lanes; l++) begin
				if (cfg_lane_i == l) begin
					case (cfg_sel_i)
						dsp_pkg::sel_weight: begin
							for (int t = 0; t < ffe_taps; t++) begin
								if (cfg_tap_i == t) begin
									cfg_o.weights[l][t] <= cfg_data_i[dsp_pkg::weight_w-1:0];
								end
							end
						end
						dsp_pkg::sel_thresh: cfg_o.thresh[l] <= cfg_data_i;
						dsp_pkg::sel_ffe_shift: begin
							cfg_o.ffe_shift[l] <= cfg_data_i[dsp_pkg::shift_w-1:0];
						end
						dsp_pkg::sel_mlsd_shift: begin
							cfg_o.mlsd_shift[l] <= cfg_data_i[dsp_pkg::shift_w-1:0];
						end
						dsp_pkg::sel_chan_est: begin
							for (int c = 0; c < dsp_pkg::num_cursors; c++) begin
								if (cfg_tap_i == c) begin
									cfg_o.chan_est[l][c] <= cfg_data_i[dsp_pkg::est_w-1:0];
								end
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dsp_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dsp_cfg_if #(
	parameter int num_lanes = dsp_pkg::default_lanes,
	parameter int ffe_taps = dsp_pkg::default_taps
);

	logic signed [dsp_pkg::weight_w-1:0] weights [num_lanes][ffe_taps];
	logic signed [dsp_pkg::code_w-1:0] thresh [num_lanes];
	logic [dsp_pkg::shift_w-1:0] ffe_shift [num_lanes];
	logic [dsp_pkg::shift_w-1:0] mlsd_shift [num_lanes];
	// cursor 0 is pre, 1 is main, 2 is post.
	logic signed [dsp_pkg::est_w-1:0] chan_est [num_lanes][dsp_pkg::num_cursors];

	modport regs (
		output weights,
		output thresh,
		output ffe_shift,
		output mlsd_shift,
		output chan_est
	);

	modport user (
		input weights,
		input thresh,
		input ffe_shift,
		input mlsd_shift,
		input chan_est
	);

endinterface

`default_nettype wire

// ==== dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

	localparam int code_w = 8;
	localparam int weight_w = 8;
	localparam int shift_w = 4;
	localparam int est_w = 8;

	localparam int default_lanes = 4;
	localparam int default_taps = 3;

	// pre, main and post cursor.
	localparam int num_cursors = 3;

	// word age of the centre word seen by the mlsd checker.
	localparam int mlsd_word = 3;

	typedef enum logic [2:0] {
		sel_weight,
		sel_thresh,
		sel_ffe_shift,
		sel_mlsd_shift,
		sel_chan_est
	} cfg_sel_e;

	function automatic int idx_w(int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

	// tap index also addresses the cursors.
	function automatic int tap_idx_w(int taps);
		return idx_w((taps > num_cursors) ? taps : num_cursors);
	endfunction

	// words kept in the code history.
	function automatic int hist_words(int lanes, int taps);
		int ffe_words;
		ffe_words = 1 + (taps - 1 + lanes - 1) / lanes;
		return (ffe_words > mlsd_word + 1) ? ffe_words : mlsd_word + 1;
	endfunction

endpackage

`default_nettype wire
